//--- files.f
+incdir+logic
logic/fp_recip_pkg.sv
logic/reciprocal_rom.sv
logic/fp_reciprocal_estimate.sv
logic/pipe_stage.sv
logic/fp_recip_resolve.sv
logic/recip_cfg_regs.sv
logic/recip_req_port.sv
logic/fp_recip_unit.sv
bench/fp_recip_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the reciprocal estimate unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module fp_recip_tb -o fp_recip_sim
./obj_dir/fp_recip_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- bench/fp_recip_tb.sv
// ****************************************
// Reciprocal estimate unit testbench
// Directed four-phase transfers checked
// against a model of the estimate rules
// ****************************************

`timescale 1ns/100ps
`default_nettype none

`include "fp_recip_macros.svh"

module fp_recip_tb;

	import fp_recip_pkg::*;

	localparam int ACK_LATENCY = 3;
	localparam int NUM_TRANSFERS = 200 + 130 + 12 + 8 + 3 + 8;
	localparam int WATCHDOG_CYCLES = NUM_TRANSFERS * 20 + 500;

	logic clk;
	logic rst_n;
	logic req;
	logic [31:0] operand;
	logic ack;
	logic [31:0] result;
	recip_flags_t flags;
	logic cfg_we;
	logic cfg_addr;
	logic [31:0] cfg_wdata;
	logic [31:0] cfg_rdata;

	int value_errors;
	int flag_errors;
	int reg_errors;
	int protocol_errors;
	string cur_test;
	logic [31:0] lcg_state;
	logic dnan_mode;

	fp_recip_unit dut
	(
		.clk_i(clk),
		.rst_n_i(rst_n),
		.req_i(req),
		.operand_i(operand),
		.ack_o(ack),
		.result_o(result),
		.flags_o(flags),
		.cfg_we_i(cfg_we),
		.cfg_addr_i(cfg_addr),
		.cfg_wdata_i(cfg_wdata),
		.cfg_rdata_o(cfg_rdata)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Fraction bits of 2/m - 1 with m at the middle of slot a
	function automatic logic [5:0] table_entry(input int a);
		int quotient;
		quotient = (64 * (127 - 2 * a)) / (129 + 2 * a);
		return quotient[5:0];
	endfunction

	function automatic recip_result_t expected_result(input logic [31:0] op, input logic dnan);
		recip_result_t r;
		int e;
		logic sign;
		logic [7:0] exp_in;
		logic [22:0] sig_in;
		sign = op[31];
		exp_in = op[30:23];
		sig_in = op[22:0];
		r.flags = '0;
		if (exp_in == 8'h00)
		begin
			// Denormals count as zero so 1/x is a signed infinity
			r.value = {sign, 8'hFF, 23'h0};
			r.flags.dz = 1'b1;
		end
		else if (exp_in == 8'hFF && sig_in == 23'h0)
			r.value = {sign, 31'h0};
		else if (exp_in == 8'hFF)
		begin
			r.value = dnan ? 32'h7FC0_0000 : {op[31:23], 1'b1, op[21:0]};
			r.flags.inv = !sig_in[22];
		end
		else
		begin
			// Power of two inputs invert exactly while the rest come from the table
			e = (sig_in == 23'h0) ? 254 - int'(exp_in) : 253 - int'(exp_in);
			if (e <= 0)
			begin
				r.value = {sign, 31'h0};
				r.flags.uf = 1'b1;
			end
			else if (sig_in == 23'h0)
				r.value = {sign, e[7:0], 23'h0};
			else
				r.value = {sign, e[7:0], table_entry(int'(sig_in[22:17])), 17'h0};
		end
		return r;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s %s: expected %h actual %h", cur_test, what, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_flags(input string what, input recip_flags_t expected,
		input recip_flags_t actual);
		if (actual !== expected)
		begin
			$display("FAILED %s %s flags: expected %b actual %b", cur_test, what, expected,
				actual);
			flag_errors++;
		end
	endtask

	task automatic check_reg(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s %s: expected %h actual %h", cur_test, what, expected, actual);
			reg_errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		req <= 1'b0;
		cfg_we <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// One full four-phase transfer with outputs sampled on the falling edge
	task automatic run_transfer(input logic [31:0] op, input int hold,
		output logic [31:0] res, output recip_flags_t flg);
		int edges;
		logic acked;
		@(posedge clk);
		operand <= op;
		req <= 1'b1;
		// The next edge is the first one that samples req high
		@(posedge clk);
		edges = 0;
		@(negedge clk);
		while (!ack && edges < 4 * ACK_LATENCY)
		begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		acked = ack;
		res = result;
		flg = flags;
		if (!acked)
		begin
			$display("Handshake timeout in %s: ack_o never rose for operand %h", cur_test, op);
			protocol_errors++;
		end
		else
		begin
			if (edges != ACK_LATENCY)
			begin
				$display("FAILED %s ack latency: expected %0d actual %0d", cur_test,
					ACK_LATENCY, edges);
				protocol_errors++;
			end
			// Host keeps req high and the response has to sit still
			for (int i = 0; i < hold; i++)
			begin
				@(posedge clk);
				@(negedge clk);
				if (!ack)
				begin
					$display("In %s ack_o dropped while req_i was still high", cur_test);
					protocol_errors++;
				end
				check_value("held result", res, result);
				check_flags("held", flg, flags);
			end
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		if (!ack && acked)
		begin
			$display("In %s ack_o fell before req_i was sampled low", cur_test);
			protocol_errors++;
		end
		@(posedge clk);
		@(negedge clk);
		if (ack)
		begin
			$display("In %s ack_o stayed high after req_i dropped", cur_test);
			protocol_errors++;
		end
	endtask

	task automatic check_transfer(input logic [31:0] op, input int hold);
		recip_result_t exp_r;
		logic [31:0] res;
		recip_flags_t flg;
		exp_r = expected_result(op, dnan_mode);
		run_transfer(op, hold, res, flg);
		check_value($sformatf("operand %h", op), exp_r.value, res);
		check_flags($sformatf("operand %h", op), exp_r.flags, flg);
	endtask

	task automatic write_reg(input logic addr, input logic [31:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic read_reg(input logic addr, output logic [31:0] data);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		data = cfg_rdata;
	endtask

	task automatic set_dnan(input logic en);
		write_reg(1'(`RECIP_REG_CTRL), {31'h0, en});
		dnan_mode = en;
	endtask

	task automatic test_normal_random();
		logic [31:0] r;
		logic [31:0] s;
		logic [7:0] e;
		cur_test = "test_normal_random";
		for (int n = 0; n < 200; n++)
		begin
			r = lcg_next();
			s = lcg_next();
			e = 8'(1 + (r[30:16] % 252));
			check_transfer({r[31], e, s[31:9]}, 0);
		end
	endtask

	task automatic test_table_sweep();
		cur_test = "test_table_sweep";
		for (int s = 0; s < 2; s++)
		begin
			// Nonzero low bits keep every address off the power of two case
			for (int a = 0; a < 64; a++)
				check_transfer({s[0], 8'd127, a[5:0], 17'h0AB5}, 0);
			check_transfer({s[0], 8'd127, 23'h0}, 0);
		end
	endtask

	task automatic test_special();
		logic [31:0] ops[6];
		cur_test = "test_special";
		ops[0] = 32'h0000_0000;
		ops[1] = 32'h8012_3456;
		ops[2] = 32'h7F80_0000;
		ops[3] = 32'hFF80_0000;
		ops[4] = 32'h7FC1_2345;
		ops[5] = 32'hFF81_2345;
		for (int m = 0; m < 2; m++)
		begin
			set_dnan(m[0]);
			for (int k = 0; k < 6; k++)
				check_transfer(ops[k], 0);
		end
		set_dnan(1'b0);
	endtask

	task automatic test_underflow();
		cur_test = "test_underflow";
		for (int s = 0; s < 2; s++)
		begin
			check_transfer({s[0], 8'd253, 23'h0}, 0);
			check_transfer({s[0], 8'd253, 23'h41_2345}, 0);
			check_transfer({s[0], 8'd254, 23'h0}, 0);
			check_transfer({s[0], 8'd254, 23'h12_3456}, 0);
		end
	endtask

	task automatic test_cfg_regs();
		logic [31:0] rd;
		cur_test = "test_cfg_regs";
		// Control is left set so the reset has something to clear
		set_dnan(1'b1);
		apply_reset();
		dnan_mode = 1'b0;
		read_reg(1'(`RECIP_REG_CTRL), rd);
		check_reg("control after reset", 32'h0, rd);
		read_reg(1'(`RECIP_REG_STATUS), rd);
		check_reg("status after reset", 32'h0, rd);
		// Status bits are dz, inv, uf from the top down
		check_transfer(32'h0000_0000, 0);
		read_reg(1'(`RECIP_REG_STATUS), rd);
		check_reg("status after dz", 32'h4, rd);
		check_transfer(32'h7F80_0001, 0);
		read_reg(1'(`RECIP_REG_STATUS), rd);
		check_reg("status after inv", 32'h6, rd);
		check_transfer(32'h7F00_0000, 0);
		read_reg(1'(`RECIP_REG_STATUS), rd);
		check_reg("status after uf", 32'h7, rd);
		write_reg(1'(`RECIP_REG_STATUS), 32'h2);
		read_reg(1'(`RECIP_REG_STATUS), rd);
		check_reg("status after clearing inv", 32'h5, rd);
		write_reg(1'(`RECIP_REG_STATUS), 32'h5);
		read_reg(1'(`RECIP_REG_STATUS), rd);
		check_reg("status after clearing all", 32'h0, rd);
		set_dnan(1'b1);
		read_reg(1'(`RECIP_REG_CTRL), rd);
		check_reg("control set", 32'h1, rd);
		set_dnan(1'b0);
		read_reg(1'(`RECIP_REG_CTRL), rd);
		check_reg("control cleared", 32'h0, rd);
	endtask

	task automatic test_handshake();
		logic [31:0] r;
		logic [31:0] s;
		int hold;
		cur_test = "test_handshake";
		for (int n = 0; n < 8; n++)
		begin
			r = lcg_next();
			s = lcg_next();
			hold = int'(lcg_next() % 6) + 1;
			check_transfer({r[31], 8'(1 + (r[30:16] % 252)), s[31:9]}, hold);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = 1'b0;
		operand = 32'h0;
		cfg_we = 1'b0;
		cfg_addr = 1'b0;
		cfg_wdata = 32'h0;
		value_errors = 0;
		flag_errors = 0;
		reg_errors = 0;
		protocol_errors = 0;
		lcg_state = 32'd94748;
		dnan_mode = 1'b0;
		cur_test = "reset";
		apply_reset();
		test_normal_random();
		test_table_sweep();
		test_special();
		test_underflow();
		test_cfg_regs();
		test_handshake();
		$display("Errors: value %0d, flags %0d, register %0d, protocol %0d",
			value_errors, flag_errors, reg_errors, protocol_errors);
		if (value_errors + flag_errors + reg_errors + protocol_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Bound on the whole run sized from the number of transfers
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/fp_recip_unit.sv
// ****************************************
// Floating-point reciprocal estimate unit
// Host handshake, two-stage datapath and
// register block
// ****************************************

`timescale 1ns/100ps
`default_nettype none

module fp_recip_unit
(
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic req_i,
	input wire logic [31:0] operand_i,
	output logic ack_o,
	output logic [31:0] result_o,
	output fp_recip_pkg::recip_flags_t flags_o,
	input wire logic cfg_we_i,
	input wire logic cfg_addr_i,
	input wire logic [31:0] cfg_wdata_i,
	output logic [31:0] cfg_rdata_o
);

	import fp_recip_pkg::*;

	logic launch_valid;
	logic [31:0] launch_operand;
	recip_raw_t raw_est;
	logic s1_valid;
	recip_raw_t s1_raw;
	recip_result_t resolved;
	logic s2_valid;
	recip_result_t s2_result;
	logic dnan_en;

	recip_req_port port
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.req_i(req_i),
		.operand_i(operand_i),
		.ack_o(ack_o),
		.result_o(result_o),
		.flags_o(flags_o),
		.launch_valid_o(launch_valid),
		.launch_operand_o(launch_operand),
		.done_valid_i(s2_valid),
		.done_i(s2_result)
	);

	// Table lookup and exponent math in the launch cycle
	fp_reciprocal_estimate estimate
	(
		.value_i(launch_operand),
		.raw_o(raw_est)
	);

	pipe_stage #(.payload_t(recip_raw_t)) stage1
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(launch_valid),
		.data_i(raw_est),
		.valid_o(s1_valid),
		.data_o(s1_raw)
	);

	// Special cases are settled between the two registers
	fp_recip_resolve resolve
	(
		.raw_i(s1_raw),
		.dnan_en_i(dnan_en),
		.result_o(resolved)
	);

	pipe_stage #(.payload_t(recip_result_t)) stage2
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.valid_i(s1_valid),
		.data_i(resolved),
		.valid_o(s2_valid),
		.data_o(s2_result)
	);

	// Flags reach the status register on the same edge as ack
	recip_cfg_regs regs
	(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.cfg_we_i(cfg_we_i),
		.cfg_addr_i(cfg_addr_i),
		.cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_o(cfg_rdata_o),
		.flag_set_i(s2_result.flags),
		.flag_set_valid_i(s2_valid),
		.dnan_en_o(dnan_en)
	);

endmodule

`default_nettype wire

//--- logic/recip_req_port.sv
// ****************************************
// Four-phase host front end
// Captures the operand, launches it and
// holds the result until req drops
// ****************************************

`timescale 1ns/100ps
`default_nettype none

module recip_req_port
(
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic req_i,
	input wire logic [31:0] operand_i,
	output logic ack_o,
	output logic [31:0] result_o,
	output fp_recip_pkg::recip_flags_t flags_o,
	output logic launch_valid_o,
	output logic [31:0] launch_operand_o,
	input wire logic done_valid_i,
	input wire fp_recip_pkg::recip_result_t done_i
);

	import fp_recip_pkg::*;

	typedef enum logic [1:0]
	{
		PORT_IDLE,
		PORT_BUSY,
		PORT_ACK
	} port_state_t;

	port_state_t state_q;
	logic launch_q;
	logic [31:0] operand_q;
	logic [31:0] result_q;
	recip_flags_t flags_q;
	logic start;

	// IDLE is only re-entered with req low so req high here is a fresh rising edge
	assign start = (state_q == PORT_IDLE) && req_i;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state_q <= PORT_IDLE;
			launch_q <= 1'b0;
		end
		else
		begin
			launch_q <= start;
			case (state_q)
				PORT_IDLE:
					if (req_i)
						state_q <= PORT_BUSY;
				PORT_BUSY:
					// Result comes back a fixed two cycles after launch
					if (done_valid_i)
						state_q <= PORT_ACK;
				PORT_ACK:
					if (!req_i)
						state_q <= PORT_IDLE;
				default:
					state_q <= PORT_IDLE;
			endcase
		end
	end

	// Operand is held for the launch cycle
	always_ff @(posedge clk_i)
	begin
		if (start)
			operand_q <= operand_i;
	end

	// Result and flags freeze for the whole ack phase
	always_ff @(posedge clk_i)
	begin
		if (state_q == PORT_BUSY && done_valid_i)
		begin
			result_q <= done_i.value;
			flags_q <= done_i.flags;
		end
	end

	assign ack_o = (state_q == PORT_ACK);
	assign result_o = result_q;
	assign flags_o = flags_q;
	assign launch_valid_o = launch_q;
	assign launch_operand_o = operand_q;

endmodule

`default_nettype wire

//--- logic/recip_cfg_regs.sv
// ****************************************
// Configuration and status registers
// Default-NaN control bit and sticky
// write-1-to-clear exception flags
// ****************************************

`timescale 1ns/100ps
`default_nettype none

`include "fp_recip_macros.svh"

module recip_cfg_regs
(
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic cfg_we_i,
	input wire logic cfg_addr_i,
	input wire logic [31:0] cfg_wdata_i,
	output logic [31:0] cfg_rdata_o,
	input wire fp_recip_pkg::recip_flags_t flag_set_i,
	input wire logic flag_set_valid_i,
	output logic dnan_en_o
);

	import fp_recip_pkg::*;

	logic dnan_en_q;
	recip_flags_t status_q;
	logic [2:0] status_kept;
	logic [2:0] status_set;
	logic ctrl_sel;
	logic status_sel;

	assign ctrl_sel = (cfg_addr_i == 1'(`RECIP_REG_CTRL));
	assign status_sel = (cfg_addr_i == 1'(`RECIP_REG_STATUS));

	// Bits written with 1 drop out of the status
	assign status_kept = (cfg_we_i && status_sel) ? (status_q & ~cfg_wdata_i[2:0]) : status_q;

	// New flags are ORed in after the clear so a set on the same edge wins
	assign status_set = flag_set_valid_i ? flag_set_i : 3'b000;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			dnan_en_q <= 1'b0;
			status_q <= '0;
		end
		else
		begin
			if (cfg_we_i && ctrl_sel)
				dnan_en_q <= cfg_wdata_i[0];
			status_q <= status_kept | status_set;
		end
	end

	// Unused bits of the read mux read as zero
	always_comb
	begin
		cfg_rdata_o = '0;
		if (ctrl_sel)
			cfg_rdata_o[0] = dnan_en_q;
		else
			cfg_rdata_o[2:0] = status_q;
	end

	assign dnan_en_o = dnan_en_q;

endmodule

`default_nettype wire

//--- logic/fp_recip_resolve.sv
// ****************************************
// Special case resolver
// Final reciprocal value and exception
// flags from the raw estimate
// ****************************************

`timescale 1ns/100ps
`default_nettype none

`include "fp_recip_macros.svh"

module fp_recip_resolve
(
	input wire fp_recip_pkg::recip_raw_t raw_i,
	input wire logic dnan_en_i,
	output fp_recip_pkg::recip_result_t result_o
);

	import fp_recip_pkg::*;

	localparam logic [31:0] DEFAULT_NAN = 32'h7FC0_0000;

	logic sign;

	assign sign = raw_i.operand[31];

	always_comb
	begin
		result_o.value = raw_i.value;
		result_o.flags = '0;
		case (raw_i.cls)
			ZERO:
			begin
				// 1/0 is an infinity of the same sign
				result_o.value = {sign, {`FP_EXP_WIDTH{1'b1}}, {`FP_SIG_WIDTH{1'b0}}};
				result_o.flags.dz = 1'b1;
			end
			INF:
			begin
				result_o.value = {sign, 31'b0};
			end
			QNAN, SNAN:
			begin
				// Without default NaN mode the payload survives but is quieted
				if (dnan_en_i)
					result_o.value = DEFAULT_NAN;
				else
					result_o.value = raw_i.operand | (32'd1 << (`FP_SIG_WIDTH - 1));
				result_o.flags.inv = (raw_i.cls == SNAN);
			end
			default:
			begin
				// A zero raw exponent on a normal operand marks an underflow
				if (raw_i.value[`FP_SIG_WIDTH +: `FP_EXP_WIDTH] == '0)
				begin
					result_o.value = {sign, 31'b0};
					result_o.flags.uf = 1'b1;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/pipe_stage.sv
// ****************************************
// Pipeline register with valid
// Payload type is a parameter
// ****************************************

`timescale 1ns/100ps
`default_nettype none

module pipe_stage
#(
	parameter type payload_t = logic [31:0]
)
(
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input wire payload_t data_i,
	output logic valid_o,
	output payload_t data_o
);

	// Valid follows the input every cycle so a launch moves as a single pulse
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// Data only moves with a valid beat
	always_ff @(posedge clk_i)
	begin
		if (valid_i)
			data_o <= data_i;
	end

endmodule

`default_nettype wire

//--- logic/fp_reciprocal_estimate.sv
// ****************************************
// Reciprocal estimate datapath
// Classifies the operand and forms the
// raw table-based reciprocal
// ****************************************

`timescale 1ns/100ps
`default_nettype none

`include "fp_recip_macros.svh"

module fp_reciprocal_estimate
(
	input wire logic [31:0] value_i,
	output fp_recip_pkg::recip_raw_t raw_o
);

	import fp_recip_pkg::*;

	localparam int EXP_CALC_WIDTH = `FP_EXP_WIDTH + 2;

	logic sign;
	logic [`FP_EXP_WIDTH-1:0] exp_in;
	logic [`FP_SIG_WIDTH-1:0] sig_in;
	logic [`RECIP_LUT_WIDTH-1:0] lut_data;
	logic [EXP_CALC_WIDTH-1:0] exp_calc;
	logic [`FP_EXP_WIDTH-1:0] exp_out;
	logic [`FP_SIG_WIDTH-1:0] sig_out;
	fp_class_t cls;

	assign sign = value_i[31];
	assign exp_in = value_i[`FP_SIG_WIDTH +: `FP_EXP_WIDTH];
	assign sig_in = value_i[`FP_SIG_WIDTH-1:0];

	// Top significand bits pick the table slot
	reciprocal_rom rom
	(
		.addr_i(sig_in[`FP_SIG_WIDTH-1 -: `RECIP_LUT_WIDTH]),
		.data_o(lut_data)
	);

	// Exponent all ones is infinity or NaN, the top fraction bit marks a quiet NaN
	always_comb
	begin
		if (exp_in == '0)
			cls = ZERO;
		else if (exp_in != '1)
			cls = NORMAL;
		else if (sig_in == '0)
			cls = INF;
		else if (sig_in[`FP_SIG_WIDTH-1])
			cls = QNAN;
		else
			cls = SNAN;
	end

	always_comb
	begin
		// An exact power of two has reciprocal 1.0, one exponent step higher
		// The table cannot hold that case since it would need a seventh bit
		if (sig_in == '0)
		begin
			exp_calc = EXP_CALC_WIDTH'(254) - {2'b00, exp_in};
			sig_out = '0;
		end
		else
		begin
			exp_calc = EXP_CALC_WIDTH'(253) - {2'b00, exp_in};
			sig_out = {lut_data, {(`FP_SIG_WIDTH - `RECIP_LUT_WIDTH){1'b0}}};
		end

		// A wrapped or zero exponent means the result is below the normal range
		if (exp_calc[EXP_CALC_WIDTH-1] || exp_calc == '0)
			exp_out = '0;
		else
			exp_out = exp_calc[`FP_EXP_WIDTH-1:0];
	end

	// Only normal operands carry a computed estimate, the rest pass the operand on
	assign raw_o.value = (cls == NORMAL) ? {sign, exp_out, sig_out} : value_i;
	assign raw_o.cls = cls;
	assign raw_o.operand = value_i;

endmodule

`default_nettype wire

//--- logic/reciprocal_rom.sv
// ****************************************
// Reciprocal significand table
// 64 entries of 2/m - 1 fraction bits,
// read combinationally
// ****************************************

`timescale 1ns/100ps
`default_nettype none

`include "fp_recip_macros.svh"

module reciprocal_rom
(
	input wire logic [`RECIP_LUT_WIDTH-1:0] addr_i,
	output logic [`RECIP_LUT_WIDTH-1:0] data_o
);

	localparam int LUT_DEPTH = 1 << `RECIP_LUT_WIDTH;

	// Each entry covers one slice of the significand range [1, 2)
	// The value is taken at the midpoint of that slice, m = 1 + (2a + 1) / 128
	// so 2/m - 1 scaled by 64 reduces to 64 * (127 - 2a) / (129 + 2a)
	function automatic logic [LUT_DEPTH-1:0][`RECIP_LUT_WIDTH-1:0] build_table();
		logic [LUT_DEPTH-1:0][`RECIP_LUT_WIDTH-1:0] tbl;
		int unsigned num;
		int unsigned den;
		for (int a = 0; a < LUT_DEPTH; a++)
		begin
			num = LUT_DEPTH * (2 * LUT_DEPTH - 1 - 2 * a);
			den = 2 * LUT_DEPTH + 1 + 2 * a;
			// Integer division floors, which is what the table wants
			tbl[a] = `RECIP_LUT_WIDTH'(num / den);
		end
		return tbl;
	endfunction

	// Whole table is a constant, built once at elaboration
	localparam logic [LUT_DEPTH-1:0][`RECIP_LUT_WIDTH-1:0] RECIP_TABLE = build_table();

	assign data_o = RECIP_TABLE[addr_i];

endmodule

`default_nettype wire

//--- logic/fp_recip_pkg.sv
// ****************************************
// Reciprocal estimate unit types
// Operand class, exception flags and the
// payloads of both pipeline stages
// ****************************************

`default_nettype none

package fp_recip_pkg;

	// Operand class, ZERO also covers denormals since they flush to zero
	typedef enum logic [2:0]
	{
		ZERO,
		NORMAL,
		INF,
		QNAN,
		SNAN
	} fp_class_t;

	// Sticky exception flags, dz lands in the top bit of the status register
	typedef struct packed
	{
		logic dz;
		logic inv;
		logic uf;
	} recip_flags_t;

	// Stage 1 payload with the unresolved estimate
	typedef struct packed
	{
		logic [31:0] value;
		fp_class_t cls;
		logic [31:0] operand;
	} recip_raw_t;

	// Stage 2 payload with the final answer
	typedef struct packed
	{
		logic [31:0] value;
		recip_flags_t flags;
	} recip_result_t;

endpackage

`default_nettype wire

//--- logic/fp_recip_macros.svh
// ****************************************
// Reciprocal estimate unit constants
// Float field widths, table width and the
// host register map
// ****************************************

`ifndef FP_RECIP_MACROS_SVH
`define FP_RECIP_MACROS_SVH

// Single-precision field widths
`define FP_EXP_WIDTH 8
`define FP_SIG_WIDTH 23

// Reciprocal table address and data width
`define RECIP_LUT_WIDTH 6

// Host register addresses
`define RECIP_REG_CTRL 0
`define RECIP_REG_STATUS 1

`endif
